/* mac_tx_pkg.sv */
package mac_tx_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning on the line
    ////////////////////////////////////////////////////////////
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [31:0] fcs_t;
    typedef logic [7:0]  ipg_t;
    // ethertype in [31:16], payload length in [15:0]
    typedef logic [31:0] hdr_t;

    // framer walk, one state per field on the wire
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DEST,
        SRC,
        TYPE,
        PAYLOAD,
        FCS
    } tx_state_t;

    ////////////////////////////////////////////////////////////
    // protocol constants
    ////////////////////////////////////////////////////////////
    localparam byte_t     PREAMBLE_BYTE = 8'h55;
    localparam int        PREAMBLE_LEN  = 7;
    localparam byte_t     SFD_BYTE      = 8'hD5;
    localparam int        MAC_LEN       = 6;
    localparam int        TYPE_LEN      = 2;
    localparam int        FCS_LEN       = 4;
    localparam eth_type_t ETH_TYPE_ARP  = 16'h0806;
    localparam mac_addr_t BROADCAST_MAC = '1;

    // values after reset
    localparam mac_addr_t DEFAULT_TARGET_MAC = 48'h00_00_00_ff_ff_ff;
    localparam mac_addr_t DEFAULT_SOURCE_MAC = 48'hff_ff_ff_00_00_00;
    localparam ipg_t      DEFAULT_IPG        = 8'd12;

    // buffering
    localparam int MAX_PAYLOAD        = 1500;
    localparam int PAYLOAD_FIFO_DEPTH = 2048;
    localparam int HDR_FIFO_DEPTH     = 32;

endpackage

/* mac_tx_sync_fifo.sv */
`timescale 1ns/10ps

module mac_tx_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 32
)(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_wr_en,
    input  logic [WIDTH-1:0]       i_wr_data,
    input  logic                   i_rd_en,
    output logic [WIDTH-1:0]       o_rd_data,
    output logic                   o_empty,
    output logic                   o_full,
    output logic [$clog2(DEPTH):0] o_free
);

    // storage, depth is a power of two so pointers wrap by themselves
    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     wr_ok;
    logic                     rd_ok;

    // drop writes when full, reads when empty
    assign wr_ok = i_wr_en & ~o_full;
    assign rd_ok = i_rd_en & ~o_empty;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
            // occupancy moves only when one side acts alone
            if (wr_ok && !rd_ok)
                count <= count + 1'b1;
            else if (rd_ok && !wr_ok)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (wr_ok)
            mem[wr_ptr] <= i_wr_data;
    end

    // first word fall through, head always visible
    assign o_rd_data = mem[rd_ptr];
    assign o_empty   = (count == '0);
    assign o_full    = (count == DEPTH);
    assign o_free    = ($clog2(DEPTH)+1)'(DEPTH) - count;

endmodule

/* mac_tx_ingress.sv */
`timescale 1ns/10ps

module mac_tx_ingress (
    input  logic                   i_clk,
    input  logic                   i_rst,
    // user byte bursts
    input  logic                   i_send_valid,
    input  logic                   i_send_last,
    input  mac_tx_pkg::byte_t      i_send_data,
    input  mac_tx_pkg::eth_type_t  i_send_type,
    input  mac_tx_pkg::frame_len_t i_send_len,
    output logic                   o_send_ready,
    // framer side
    input  logic                   i_hdr_rd,
    output mac_tx_pkg::hdr_t       o_hdr,
    output logic                   o_hdr_empty,
    input  logic                   i_pay_rd,
    output mac_tx_pkg::byte_t      o_pay_data
);

    import mac_tx_pkg::*;

    logic                                   in_frame;
    logic                                   hdr_wr;
    hdr_t                                   hdr_word;
    logic                                   hdr_full;
    logic [$clog2(PAYLOAD_FIFO_DEPTH):0]    pay_free;

    // high between first and last byte of a burst
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            in_frame <= 1'b0;
        else if (i_send_valid)
            in_frame <= ~i_send_last;
    end

    // first valid byte of a burst pushes type and length
    assign hdr_wr   = i_send_valid & ~in_frame;
    assign hdr_word = {i_send_type, i_send_len};

    // room for one more worst case frame and a header slot
    assign o_send_ready = ~in_frame & ~hdr_full & (pay_free >= MAX_PAYLOAD);

    ////////////////////////////////////////////////////////////
    // payload bytes
    ////////////////////////////////////////////////////////////
    mac_tx_sync_fifo #(
        .WIDTH ($bits(byte_t)),
        .DEPTH (PAYLOAD_FIFO_DEPTH)
    ) u_pay_fifo (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (i_send_valid),
        .i_wr_data (i_send_data),
        .i_rd_en   (i_pay_rd),
        .o_rd_data (o_pay_data),
        .o_empty   (),
        .o_full    (),
        .o_free    (pay_free)
    );

    ////////////////////////////////////////////////////////////
    // per-frame header words
    ////////////////////////////////////////////////////////////
    mac_tx_sync_fifo #(
        .WIDTH ($bits(hdr_t)),
        .DEPTH (HDR_FIFO_DEPTH)
    ) u_hdr_fifo (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (hdr_wr),
        .i_wr_data (hdr_word),
        .i_rd_en   (i_hdr_rd),
        .o_rd_data (o_hdr),
        .o_empty   (o_hdr_empty),
        .o_full    (hdr_full),
        .o_free    ()
    );

endmodule

/* mac_tx_crc32.sv */
`timescale 1ns/10ps

module mac_tx_crc32 (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_init,
    input  logic              i_en,
    input  mac_tx_pkg::byte_t i_data,
    output mac_tx_pkg::fcs_t  o_fcs
);

    import mac_tx_pkg::*;

    // reflected form of 0x04C11DB7
    localparam fcs_t CRC_POLY = 32'hEDB88320;

    fcs_t crc_q;
    fcs_t crc_next;
    fcs_t crc_inv;

    // one byte, lsb first, shift right form
    always_comb
    begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++)
        begin
            if (crc_next[0] ^ i_data[i])
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            crc_q <= '1;
        else if (i_init)
            crc_q <= '1;
        else if (i_en)
            crc_q <= crc_next;
    end

    // low byte of the complement goes on the wire first
    assign crc_inv = ~crc_q;
    assign o_fcs   = {crc_inv[7:0], crc_inv[15:8], crc_inv[23:16], crc_inv[31:24]};

endmodule

/* mac_tx_ipg_timer.sv */
`timescale 1ns/10ps

module mac_tx_ipg_timer (
    input  logic             i_clk,
    input  logic             i_rst,
    input  mac_tx_pkg::ipg_t i_ipg,
    input  logic             i_ipg_valid,
    input  logic             i_tx_valid,
    output logic             o_gap_done
);

    import mac_tx_pkg::*;

    ipg_t gap_q;
    ipg_t idle_cnt;

    // programmed gap
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            gap_q <= DEFAULT_IPG;
        else if (i_ipg_valid)
            gap_q <= i_ipg;
    end

    // idle cycles since the last byte, starts satisfied
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            idle_cnt <= DEFAULT_IPG;
        else if (i_tx_valid)
            idle_cnt <= '0;
        else if (idle_cnt < gap_q)
            idle_cnt <= idle_cnt + 1'b1;
    end

    // a smaller gap loaded mid-count is met at once
    assign o_gap_done = ~i_tx_valid & (idle_cnt >= gap_q);

endmodule

/* mac_tx_framer.sv */
`timescale 1ns/10ps

module mac_tx_framer (
    input  logic                  i_clk,
    input  logic                  i_rst,
    // address config strobes
    input  mac_tx_pkg::mac_addr_t i_target_mac,
    input  logic                  i_target_mac_valid,
    input  mac_tx_pkg::mac_addr_t i_source_mac,
    input  logic                  i_source_mac_valid,
    // header and payload fifos
    input  mac_tx_pkg::hdr_t      i_hdr,
    input  logic                  i_hdr_empty,
    output logic                  o_hdr_rd,
    input  mac_tx_pkg::byte_t     i_pay_data,
    output logic                  o_pay_rd,
    // start gating
    input  logic                  i_gap_done,
    input  logic                  i_tx_ready,
    // crc engine
    output logic                  o_crc_init,
    output logic                  o_crc_en,
    output mac_tx_pkg::byte_t     o_crc_data,
    input  mac_tx_pkg::fcs_t      i_fcs,
    // line side
    output mac_tx_pkg::byte_t     o_tx_data,
    output logic                  o_tx_valid,
    output logic                  o_tx_last,
    output logic [15:0]           o_tx_frames_cnt
);

    import mac_tx_pkg::*;

    tx_state_t  state;
    tx_state_t  next_state;
    frame_len_t byte_idx;
    frame_len_t last_idx;
    logic       start;
    byte_t      tx_byte;
    mac_addr_t  target_mac_q;
    mac_addr_t  source_mac_q;
    mac_addr_t  frm_dst;
    mac_addr_t  frm_src;
    eth_type_t  frm_type;
    frame_len_t frm_len;
    logic [15:0] frames_cnt;

    ////////////////////////////////////////////////////////////
    // address registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            target_mac_q <= DEFAULT_TARGET_MAC;
            source_mac_q <= DEFAULT_SOURCE_MAC;
        end
        else
        begin
            if (i_target_mac_valid)
                target_mac_q <= i_target_mac;
            if (i_source_mac_valid)
                source_mac_q <= i_source_mac;
        end
    end

    // queued header, open gap, ready line, nothing in flight
    assign start    = (state == IDLE) & ~i_hdr_empty & i_gap_done & i_tx_ready;
    assign o_hdr_rd = start;

    // per-frame fields, frozen so config writes cannot tear a frame
    always_ff @(posedge i_clk)
    begin
        if (start)
        begin
            frm_type <= i_hdr[31:16];
            frm_len  <= i_hdr[15:0];
            frm_src  <= source_mac_q;
            // arp always goes to broadcast
            if (i_hdr[31:16] == ETH_TYPE_ARP)
                frm_dst <= BROADCAST_MAC;
            else
                frm_dst <= target_mac_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // field walk
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        next_state = IDLE;
        last_idx   = '0;
        case (state)
            PREAMBLE:
            begin
                next_state = SFD;
                last_idx   = frame_len_t'(PREAMBLE_LEN - 1);
            end
            SFD:     next_state = DEST;
            DEST:
            begin
                next_state = SRC;
                last_idx   = frame_len_t'(MAC_LEN - 1);
            end
            SRC:
            begin
                next_state = TYPE;
                last_idx   = frame_len_t'(MAC_LEN - 1);
            end
            TYPE:
            begin
                next_state = PAYLOAD;
                last_idx   = frame_len_t'(TYPE_LEN - 1);
            end
            PAYLOAD:
            begin
                next_state = FCS;
                last_idx   = frm_len - 1'b1;
            end
            FCS:     last_idx = frame_len_t'(FCS_LEN - 1);
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            state      <= IDLE;
            byte_idx   <= '0;
            frames_cnt <= '0;
        end
        else if (state == IDLE)
        begin
            byte_idx <= '0;
            if (start)
            begin
                state      <= PREAMBLE;
                frames_cnt <= frames_cnt + 1'b1;
            end
        end
        else if (byte_idx == last_idx)
        begin
            state    <= next_state;
            byte_idx <= '0;
        end
        else
            byte_idx <= byte_idx + 1'b1;
    end

    // byte on the line this cycle, fields sent msb first
    always_comb
    begin
        tx_byte = '0;
        case (state)
            PREAMBLE: tx_byte = PREAMBLE_BYTE;
            SFD:      tx_byte = SFD_BYTE;
            DEST:     tx_byte = frm_dst[8*(MAC_LEN-1-byte_idx) +: 8];
            SRC:      tx_byte = frm_src[8*(MAC_LEN-1-byte_idx) +: 8];
            TYPE:     tx_byte = frm_type[8*(TYPE_LEN-1-byte_idx) +: 8];
            PAYLOAD:  tx_byte = i_pay_data;
            FCS:      tx_byte = i_fcs[8*(FCS_LEN-1-byte_idx) +: 8];
            default:  tx_byte = '0;
        endcase
    end

    // preset during sfd, crc covers dest through payload
    assign o_crc_init = (state == SFD);
    assign o_crc_en   = (state == DEST) | (state == SRC) | (state == TYPE) | (state == PAYLOAD);
    assign o_crc_data = tx_byte;
    // one pop per payload byte shown
    assign o_pay_rd   = (state == PAYLOAD);

    assign o_tx_data       = tx_byte;
    assign o_tx_valid      = (state != IDLE);
    assign o_tx_last       = (state == FCS) & (byte_idx == last_idx);
    assign o_tx_frames_cnt = frames_cnt;

endmodule

/* mac_tx_top.sv */
`timescale 1ns/10ps

module mac_tx_top (
    input  logic                   i_clk,
    input  logic                   i_rst,
    // run-time config
    input  mac_tx_pkg::mac_addr_t  i_target_mac,
    input  logic                   i_target_mac_valid,
    input  mac_tx_pkg::mac_addr_t  i_source_mac,
    input  logic                   i_source_mac_valid,
    input  mac_tx_pkg::ipg_t       i_ipg,
    input  logic                   i_ipg_valid,
    // user side
    input  logic                   i_send_valid,
    input  logic                   i_send_last,
    input  mac_tx_pkg::byte_t      i_send_data,
    input  mac_tx_pkg::eth_type_t  i_send_type,
    input  mac_tx_pkg::frame_len_t i_send_len,
    output logic                   o_send_ready,
    // line side
    output mac_tx_pkg::byte_t      o_tx_data,
    output logic                   o_tx_valid,
    output logic                   o_tx_last,
    input  logic                   i_tx_ready,
    output logic [15:0]            o_tx_frames_cnt
);

    import mac_tx_pkg::*;

    hdr_t  hdr;
    logic  hdr_empty;
    logic  hdr_rd;
    byte_t pay_data;
    logic  pay_rd;
    logic  crc_init;
    logic  crc_en;
    byte_t crc_data;
    fcs_t  fcs;
    logic  gap_done;

    ////////////////////////////////////////////////////////////
    // buffering, framing, fcs, gap
    ////////////////////////////////////////////////////////////
    mac_tx_ingress u_ingress (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_send_valid (i_send_valid),
        .i_send_last  (i_send_last),
        .i_send_data  (i_send_data),
        .i_send_type  (i_send_type),
        .i_send_len   (i_send_len),
        .o_send_ready (o_send_ready),
        .i_hdr_rd     (hdr_rd),
        .o_hdr        (hdr),
        .o_hdr_empty  (hdr_empty),
        .i_pay_rd     (pay_rd),
        .o_pay_data   (pay_data)
    );

    mac_tx_framer u_framer (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_target_mac       (i_target_mac),
        .i_target_mac_valid (i_target_mac_valid),
        .i_source_mac       (i_source_mac),
        .i_source_mac_valid (i_source_mac_valid),
        .i_hdr              (hdr),
        .i_hdr_empty        (hdr_empty),
        .o_hdr_rd           (hdr_rd),
        .i_pay_data         (pay_data),
        .o_pay_rd           (pay_rd),
        .i_gap_done         (gap_done),
        .i_tx_ready         (i_tx_ready),
        .o_crc_init         (crc_init),
        .o_crc_en           (crc_en),
        .o_crc_data         (crc_data),
        .i_fcs              (fcs),
        .o_tx_data          (o_tx_data),
        .o_tx_valid         (o_tx_valid),
        .o_tx_last          (o_tx_last),
        .o_tx_frames_cnt    (o_tx_frames_cnt)
    );

    mac_tx_crc32 u_crc (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_init (crc_init),
        .i_en   (crc_en),
        .i_data (crc_data),
        .o_fcs  (fcs)
    );

    // gap counts from the end of the line valid
    mac_tx_ipg_timer u_ipg (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_ipg       (i_ipg),
        .i_ipg_valid (i_ipg_valid),
        .i_tx_valid  (o_tx_valid),
        .o_gap_done  (gap_done)
    );

endmodule

/* tb_mac_tx.sv */
`timescale 1ns/10ps

module tb_mac_tx;

    import mac_tx_pkg::*;

    localparam int CLK_PERIOD = 20;

    logic        i_clk;
    logic        i_rst;
    logic [47:0] i_target_mac;
    logic        i_target_mac_valid;
    logic [47:0] i_source_mac;
    logic        i_source_mac_valid;
    logic [7:0]  i_ipg;
    logic        i_ipg_valid;
    logic        i_send_valid;
    logic        i_send_last;
    logic [7:0]  i_send_data;
    logic [15:0] i_send_type;
    logic [15:0] i_send_len;
    logic        o_send_ready;
    logic [7:0]  o_tx_data;
    logic        o_tx_valid;
    logic        o_tx_last;
    logic        i_tx_ready;
    logic [15:0] o_tx_frames_cnt;

    // expected line bytes and a flag for the final fcs byte
    logic [7:0]  exp_q [$];
    logic        exp_last_q [$];

    // record kind is 0 for config, 1 for a frame and 2 for a crc check vector
    int          rec_kind [$];
    logic [47:0] rec_a [$];
    logic [47:0] rec_b [$];
    int          rec_n [$];
    int          rec_off [$];
    logic [7:0]  rec_bytes [$];

    int          n_frames;
    int          sent_frames;
    int          rx_frames;
    int          min_gap;
    int          idle_cycles;
    logic        mid_frame;
    logic        ready_prev;
    logic [47:0] cur_target;
    logic [47:0] cur_source;
    longint      budget;
    logic        budget_set;

    mac_tx_top dut (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_target_mac       (i_target_mac),
        .i_target_mac_valid (i_target_mac_valid),
        .i_source_mac       (i_source_mac),
        .i_source_mac_valid (i_source_mac_valid),
        .i_ipg              (i_ipg),
        .i_ipg_valid        (i_ipg_valid),
        .i_send_valid       (i_send_valid),
        .i_send_last        (i_send_last),
        .i_send_data        (i_send_data),
        .i_send_type        (i_send_type),
        .i_send_len         (i_send_len),
        .o_send_ready       (o_send_ready),
        .o_tx_data          (o_tx_data),
        .o_tx_valid         (o_tx_valid),
        .o_tx_last          (o_tx_last),
        .i_tx_ready         (i_tx_ready),
        .o_tx_frames_cnt    (o_tx_frames_cnt)
    );

    always #(CLK_PERIOD/2) i_clk = ~i_clk;

    task automatic stop_with(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // reflected ethernet crc-32 preset to all ones and complemented at the end
    function automatic logic [31:0] crc32_ref(input logic [7:0] data [$]);
        logic [31:0] r;
        r = 32'hFFFFFFFF;
        foreach (data[k])
        begin
            r = r ^ {24'd0, data[k]};
            for (int j = 0; j < 8; j++)
            begin
                if (r[0])
                    r = (r >> 1) ^ 32'hEDB88320;
                else
                    r = r >> 1;
            end
        end
        return ~r;
    endfunction

    ////////////////////////////////////////////////////////////
    // golden file
    ////////////////////////////////////////////////////////////
    task automatic read_golden();
        int          fd;
        int          n;
        int          c;
        int          gap;
        string       tag;
        string       rest;
        logic [47:0] a;
        logic [47:0] b;
        logic [7:0]  bv;
        gap = DEFAULT_IPG;
        budget = 2000;
        fd = $fopen("mac_tx_golden.txt", "r");
        if (fd == 0)
            stop_with("could not open the golden file mac_tx_golden.txt");
        while (!$feof(fd))
        begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1)
                break;
            if (tag == "#")
                n = $fgets(rest, fd);
            else if (tag == "C")
            begin
                n = $fscanf(fd, "%h %h %d", a, b, c);
                rec_kind.push_back(0);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_n.push_back(c);
                rec_off.push_back(rec_bytes.size());
                gap = c;
            end
            else if (tag == "F" || tag == "E")
            begin
                a = '0;
                if (tag == "F")
                    n = $fscanf(fd, "%h %d", a, c);
                else
                    n = $fscanf(fd, "%d", c);
                rec_off.push_back(rec_bytes.size());
                for (int i = 0; i < c; i++)
                begin
                    n = $fscanf(fd, "%h", bv);
                    rec_bytes.push_back(bv);
                end
                // check vectors carry their crc after the bytes
                if (tag == "E")
                    n = $fscanf(fd, "%h", a);
                rec_kind.push_back(tag == "F" ? 1 : 2);
                rec_a.push_back(a);
                rec_b.push_back('0);
                rec_n.push_back(c);
                if (tag == "F")
                begin
                    n_frames++;
                    budget += longint'(c + 26 + gap + 50);
                end
            end
            else
                stop_with("unknown record tag in the golden file");
        end
        $fclose(fd);
    endtask

    // known crc vectors prove the reference model first
    task automatic check_crc_model();
        logic [7:0]  q [$];
        logic [31:0] got;
        foreach (rec_kind[r])
        begin
            if (rec_kind[r] == 2)
            begin
                q.delete();
                for (int i = 0; i < rec_n[r]; i++)
                    q.push_back(rec_bytes[rec_off[r] + i]);
                got = crc32_ref(q);
                assert (got == rec_a[r][31:0])
                else
                    stop_with($sformatf("CHECK FAILED crc32_ref got %h expected %h",
                                        got, rec_a[r][31:0]));
            end
        end
    endtask

    // wait until every sent frame has left the line
    task automatic wait_line_idle();
        @(posedge i_clk);
        while (rx_frames != sent_frames || o_tx_valid)
            @(posedge i_clk);
    endtask

    task automatic apply_config(input int r);
        wait_line_idle();
        #2;
        i_target_mac       = rec_a[r];
        i_source_mac       = rec_b[r];
        i_ipg              = 8'(rec_n[r]);
        i_target_mac_valid = 1'b1;
        i_source_mac_valid = 1'b1;
        i_ipg_valid        = 1'b1;
        @(posedge i_clk);
        #2;
        i_target_mac_valid = 1'b0;
        i_source_mac_valid = 1'b0;
        i_ipg_valid        = 1'b0;
        cur_target = rec_a[r];
        cur_source = rec_b[r];
        min_gap    = rec_n[r];
    endtask

    ////////////////////////////////////////////////////////////
    // send one frame and queue its expected line bytes
    ////////////////////////////////////////////////////////////
    task automatic send_frame(input int r);
        logic [7:0]  crc_in [$];
        logic [47:0] dst;
        logic [15:0] etype;
        logic [31:0] fcs;
        int          len;
        etype = rec_a[r][15:0];
        len   = rec_n[r];
        dst   = (etype == ETH_TYPE_ARP) ? BROADCAST_MAC : cur_target;
        for (int i = 0; i < 6; i++)
            crc_in.push_back(dst[8*(5-i) +: 8]);
        for (int i = 0; i < 6; i++)
            crc_in.push_back(cur_source[8*(5-i) +: 8]);
        crc_in.push_back(etype[15:8]);
        crc_in.push_back(etype[7:0]);
        for (int i = 0; i < len; i++)
            crc_in.push_back(rec_bytes[rec_off[r] + i]);
        fcs = crc32_ref(crc_in);
        for (int i = 0; i < 7; i++)
            exp_q.push_back(8'h55);
        exp_q.push_back(8'hD5);
        foreach (crc_in[i])
            exp_q.push_back(crc_in[i]);
        // fcs goes out low byte first
        for (int i = 0; i < 4; i++)
            exp_q.push_back(fcs[8*i +: 8]);
        for (int i = 0; i < len + 25; i++)
            exp_last_q.push_back(1'b0);
        exp_last_q.push_back(1'b1);
        sent_frames++;

        @(posedge i_clk);
        while (!o_send_ready)
            @(posedge i_clk);
        for (int i = 0; i < len; i++)
        begin
            #2;
            i_send_valid = 1'b1;
            i_send_last  = (i == len - 1);
            i_send_data  = rec_bytes[rec_off[r] + i];
            i_send_type  = etype;
            i_send_len   = 16'(len);
            @(posedge i_clk);
            // random holes inside the burst
            if (i != len - 1 && ($urandom % 4) == 0)
            begin
                #2;
                i_send_valid = 1'b0;
                @(posedge i_clk);
            end
        end
        #2;
        i_send_valid = 1'b0;
        i_send_last  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // line monitor
    ////////////////////////////////////////////////////////////
    always @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            if (o_tx_valid)
            begin
                assert (exp_q.size() != 0)
                else
                    stop_with("a byte was sent on the line with no frame expected");
                if (!mid_frame)
                begin
                    assert (idle_cycles >= min_gap)
                    else
                        stop_with($sformatf(
                            "CHECK FAILED idle_cycles got %h expected at least %h",
                            idle_cycles, min_gap));
                    // the start cycle is the one before the first preamble byte
                    assert (ready_prev)
                    else
                        stop_with("a frame started while i_tx_ready was low");
                end
                assert (o_tx_data == exp_q[0])
                else
                    stop_with($sformatf("CHECK FAILED o_tx_data got %h expected %h",
                                        o_tx_data, exp_q[0]));
                assert (o_tx_last == exp_last_q[0])
                else
                    stop_with($sformatf("CHECK FAILED o_tx_last got %h expected %h",
                                        o_tx_last, exp_last_q[0]));
                void'(exp_q.pop_front());
                void'(exp_last_q.pop_front());
                idle_cycles = 0;
                mid_frame   = !o_tx_last;
                if (o_tx_last)
                    rx_frames++;
            end
            else
            begin
                assert (!mid_frame)
                else
                    stop_with("o_tx_valid dropped in the middle of a frame");
                idle_cycles++;
            end
            ready_prev = i_tx_ready;
        end
    end

    // downstream ready drops for a random span after each frame end
    initial
    begin
        i_tx_ready = 1'b1;
        wait (budget_set && !i_rst);
        forever
        begin
            @(posedge i_clk);
            if (o_tx_valid && o_tx_last)
            begin
                #2;
                i_tx_ready = 1'b0;
                repeat (1 + $urandom % 40) @(posedge i_clk);
                #2;
                i_tx_ready = 1'b1;
            end
        end
    end

    // watchdog
    initial
    begin
        wait (budget_set);
        #(budget * CLK_PERIOD);
        stop_with("timeout, the frames were not all transmitted in time");
    end

    initial
    begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_target_mac = '0;
        i_target_mac_valid = 1'b0;
        i_source_mac = '0;
        i_source_mac_valid = 1'b0;
        i_ipg = '0;
        i_ipg_valid = 1'b0;
        i_send_valid = 1'b0;
        i_send_last = 1'b0;
        i_send_data = '0;
        i_send_type = '0;
        i_send_len = '0;
        n_frames = 0;
        sent_frames = 0;
        rx_frames = 0;
        min_gap = DEFAULT_IPG;
        idle_cycles = 1000;
        mid_frame = 1'b0;
        ready_prev = 1'b0;
        cur_target = DEFAULT_TARGET_MAC;
        cur_source = DEFAULT_SOURCE_MAC;
        budget_set = 1'b0;
        void'($urandom(72));

        read_golden();
        check_crc_model();
        budget_set = 1'b1;

        repeat (16) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        @(posedge i_clk);
        // state right after reset
        assert (!o_tx_valid && !o_tx_last)
        else
            stop_with($sformatf("CHECK FAILED o_tx_valid/o_tx_last got %h expected %h",
                                {o_tx_valid, o_tx_last}, 2'b00));
        assert (o_send_ready)
        else
            stop_with($sformatf("CHECK FAILED o_send_ready got %h expected %h",
                                o_send_ready, 1'b1));
        assert (o_tx_frames_cnt == 16'd0)
        else
            stop_with($sformatf("CHECK FAILED o_tx_frames_cnt got %h expected %h",
                                o_tx_frames_cnt, 16'd0));

        foreach (rec_kind[r])
        begin
            if (rec_kind[r] == 0)
                apply_config(r);
            else if (rec_kind[r] == 1)
                send_frame(r);
        end
        wait_line_idle();
        repeat (4) @(posedge i_clk);
        assert (o_tx_frames_cnt == 16'(n_frames))
        else
            stop_with($sformatf("CHECK FAILED o_tx_frames_cnt got %h expected %h",
                                o_tx_frames_cnt, 16'(n_frames)));
        assert (exp_q.size() == 0)
        else
            stop_with("frames were expected on the line but never arrived");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* mac_tx_golden.txt */
# C target_mac(hex) source_mac(hex) gap(dec) | E len(dec) bytes(hex) crc32(hex)
# F ethertype(hex) len(dec) then payload bytes(hex)
E 0 00000000
E 1 61 e8b7be43
E 9 31 32 33 34 35 36 37 38 39 cbf43926
# default addresses
F 0800 16
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
F 0800 1
a5
# new addresses, ipv6 frame then arp to broadcast
C 021122334455 02aabbccddee 12
F 86dd 20
60 00 00 00 00 14 06 40 fe 80
00 00 00 00 00 00 02 11 22 33
F 0806 28
00 01 08 00 06 04 00 01 02 aa
bb cc dd ee c0 a8 01 02 00 00
00 00 00 00 c0 a8 01 01
# gap 20, back to back frames
C 021122334455 02aabbccddee 20
F 0800 46
45 00 00 2e 12 34 40 00 40 11
b7 2c c0 a8 01 02 c0 a8 01 01
30 39 30 3a 00 1a 00 00 de ad
be ef ca fe ba be 00 11 22 33
44 55 66 77 88 99
F 88b5 5
ff 00 ff 00 5a
F 0800 12
10 20 30 40 50 60 70 80 90 a0 b0 c0
F 0801 30
01 23 45 67 89 ab cd ef fe dc
ba 98 76 54 32 10 00 11 22 33
44 55 66 77 88 99 aa bb cc dd

/* project.f */
mac_tx_pkg.sv
mac_tx_sync_fifo.sv
mac_tx_ingress.sv
mac_tx_crc32.sv
mac_tx_ipg_timer.sv
mac_tx_framer.sv
mac_tx_top.sv
tb_mac_tx.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator; pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal -f project.f --top-module tb_mac_tx -o sim_mac_tx &&
./obj_dir/sim_mac_tx | tee /dev/stderr | grep -q "^TESTS PASSED$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
